// ==== hdl/ternary_pkg.sv ====
// Trit coding, word sizes, opcodes and vector types; imported by every ALU block
package ternary_pkg;

    // Word geometry
    localparam int WORD_TRITS = 8;
    localparam int TRIT_BITS  = 2;
    localparam int WORD_BITS  = WORD_TRITS * TRIT_BITS;
    localparam int SHIFT_BITS = 3;  // Counts 0 to WORD_TRITS-1

    // One coded trit
    typedef logic [TRIT_BITS-1:0] trit_t;

    // One coded word, trit 0 in the low bits
    typedef logic [WORD_BITS-1:0] word_t;

    // Three coded trits of opcode
    typedef logic [3*TRIT_BITS-1:0] opcode_t;

    // Shift count in trits
    typedef logic [SHIFT_BITS-1:0] shift_t;

    // Balanced-ternary codes, pattern 10 unused and read as zero
    localparam trit_t TRIT_NEG  = 2'b11;
    localparam trit_t TRIT_ZERO = 2'b00;
    localparam trit_t TRIT_POS  = 2'b01;

    // Logic operations
    localparam opcode_t OP_NOT  = 6'b000011;  // 2
    localparam opcode_t OP_AND  = 6'b000101;  // 4
    localparam opcode_t OP_OR   = 6'b000111;  // 5
    localparam opcode_t OP_XOR  = 6'b001100;  // 6

    // Arithmetic
    localparam opcode_t OP_ADD  = 6'b001101;  // 7
    localparam opcode_t OP_SUB  = 6'b001111;  // 8

    // Equality test, result in trit 0
    localparam opcode_t OP_COMP = 6'b010011;  // 11

    // Immediate forms, same datapath as AND and ADD
    localparam opcode_t OP_ANDI = 6'b010100;  // 12
    localparam opcode_t OP_ADDI = 6'b010101;  // 13

    // Shifts by the unweighted trit sum of operand B
    localparam opcode_t OP_SRI  = 6'b010111;  // 14
    localparam opcode_t OP_SLI  = 6'b011100;  // 15

endpackage

// ==== hdl/operand_stage.sv ====
// First ALU pipeline register; cleans up operand trits and derives the shift count
`timescale 1ns/10ps

module operand_stage (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  ternary_pkg::opcode_t opcode,
    input  ternary_pkg::word_t   operand_a,
    input  ternary_pkg::word_t   operand_b,
    output logic                 stage_valid,
    output ternary_pkg::opcode_t stage_opcode,
    output ternary_pkg::word_t   stage_a,
    output ternary_pkg::word_t   stage_b,
    output ternary_pkg::shift_t  shift_amount
);
    import ternary_pkg::*;

    word_t  norm_a;
    word_t  norm_b;
    shift_t shift_next;

    // Map the unused pattern 10 onto zero, trit by trit
    function automatic word_t normalize(input word_t raw);
        word_t clean;
        clean = raw;
        for (int i = 0; i < WORD_TRITS; i++) begin
            if (raw[i*TRIT_BITS +: TRIT_BITS] == 2'b10) begin
                clean[i*TRIT_BITS +: TRIT_BITS] = TRIT_ZERO;
            end
        end
        return clean;
    endfunction

    // Plain sum of trit values, no positional weight
    function automatic shift_t trit_sum_count(input word_t w);
        int total;
        total = 0;
        for (int i = 0; i < WORD_TRITS; i++) begin
            if (w[i*TRIT_BITS +: TRIT_BITS] == TRIT_POS) begin
                total = total + 1;
            end else if (w[i*TRIT_BITS +: TRIT_BITS] == TRIT_NEG) begin
                total = total - 1;
            end
        end
        // Negative sums shift by nothing
        if (total < 0) begin
            total = 0;
        end
        if (total > WORD_TRITS - 1) begin
            total = WORD_TRITS - 1;  // Sum of +8 saturates
        end
        return shift_t'(total);
    endfunction

    assign norm_a     = normalize(operand_a);
    assign norm_b     = normalize(operand_b);
    assign shift_next = trit_sum_count(norm_b);

    // Valid flag follows the input strobe every cycle
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= in_valid;
        end
    end

    // Payload captured on a strobe only
    always_ff @(posedge clock) begin
        if (in_valid) begin
            stage_opcode <= opcode;
            stage_a      <= norm_a;
            stage_b      <= norm_b;
            shift_amount <= shift_next;
        end
    end

endmodule

// ==== hdl/trit_slice.sv ====
// One trit position of the ALU datapath; logic functions plus add and subtract carry stages
`timescale 1ns/10ps

module trit_slice (
    input  ternary_pkg::trit_t a_trit,
    input  ternary_pkg::trit_t b_trit,
    input  ternary_pkg::trit_t add_carry_in,
    input  ternary_pkg::trit_t sub_carry_in,
    output ternary_pkg::trit_t not_trit,
    output ternary_pkg::trit_t and_trit,
    output ternary_pkg::trit_t or_trit,
    output ternary_pkg::trit_t xor_trit,
    output ternary_pkg::trit_t sum_trit,
    output ternary_pkg::trit_t diff_trit,
    output ternary_pkg::trit_t add_carry_out,
    output ternary_pkg::trit_t sub_carry_out,
    output logic               trits_equal
);
    import ternary_pkg::*;

    logic signed [2:0]         a_val;
    logic signed [2:0]         b_val;
    trit_t                     neg_b;
    logic [2*TRIT_BITS-1:0]    add_step;  // {carry, sum}
    logic [2*TRIT_BITS-1:0]    sub_step;

    // Decode to -1, 0 or +1
    function automatic logic signed [2:0] trit_value(input trit_t t);
        case (t)
            TRIT_POS: return 3'sd1;
            TRIT_NEG: return -3'sd1;
            default:  return 3'sd0;  // 00 and 10
        endcase
    endfunction

    // Encode a value already known to be in -1..+1
    function automatic trit_t value_trit(input logic signed [2:0] v);
        if (v > 3'sd0) begin
            return TRIT_POS;
        end else if (v < 3'sd0) begin
            return TRIT_NEG;
        end
        return TRIT_ZERO;
    endfunction

    // Balanced full adder over three trits, total in -3..+3
    function automatic logic [2*TRIT_BITS-1:0] full_add(input trit_t x, input trit_t y,
                                                        input trit_t c);
        logic signed [2:0] total;
        total = trit_value(x) + trit_value(y) + trit_value(c);
        if (total > 3'sd1) begin
            return {TRIT_POS, value_trit(total - 3'sd3)};
        end else if (total < -3'sd1) begin
            return {TRIT_NEG, value_trit(total + 3'sd3)};
        end
        return {TRIT_ZERO, value_trit(total)};
    endfunction

    assign a_val = trit_value(a_trit);
    assign b_val = trit_value(b_trit);
    assign neg_b = value_trit(-b_val);

    assign not_trit    = value_trit(-a_val);
    assign and_trit    = value_trit((a_val < b_val) ? a_val : b_val);  // Minimum
    assign or_trit     = value_trit((a_val > b_val) ? a_val : b_val);  // Maximum
    assign trits_equal = (a_val == b_val);

    // Zero passes the other trit; equal nonzero gives -1; opposite gives 0
    always_comb begin
        if (a_val == 3'sd0) begin
            xor_trit = value_trit(b_val);
        end else if (b_val == 3'sd0) begin
            xor_trit = value_trit(a_val);
        end else if (a_val == b_val) begin
            xor_trit = TRIT_NEG;
        end else begin
            xor_trit = TRIT_ZERO;
        end
    end

    assign add_step = full_add(a_trit, b_trit, add_carry_in);
    assign sub_step = full_add(a_trit, neg_b, sub_carry_in);  // A plus negated B

    assign sum_trit      = add_step[TRIT_BITS-1:0];
    assign add_carry_out = add_step[2*TRIT_BITS-1:TRIT_BITS];
    assign diff_trit     = sub_step[TRIT_BITS-1:0];
    assign sub_carry_out = sub_step[2*TRIT_BITS-1:TRIT_BITS];

endmodule

// ==== hdl/result_stage.sv ====
// Second ALU pipeline register; shifts, equality, opcode select and the output strobe
`timescale 1ns/10ps

module result_stage (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          stage_valid,
    input  ternary_pkg::opcode_t          stage_opcode,
    input  ternary_pkg::word_t            stage_a,
    input  ternary_pkg::shift_t           shift_amount,
    input  ternary_pkg::word_t            not_word,
    input  ternary_pkg::word_t            and_word,
    input  ternary_pkg::word_t            or_word,
    input  ternary_pkg::word_t            xor_word,
    input  ternary_pkg::word_t            sum_word,
    input  ternary_pkg::word_t            diff_word,
    input  logic [ternary_pkg::WORD_TRITS-1:0] equal_bits,
    output logic                          out_valid,
    output ternary_pkg::word_t            result
);
    import ternary_pkg::*;

    word_t shift_right;
    word_t shift_left;
    word_t comp_word;
    word_t result_next;
    logic  words_equal;

    // Zero code is 00, so a logical shift fills with zero trits
    assign shift_right = stage_a >> (TRIT_BITS * shift_amount);  // Toward trit 0
    assign shift_left  = stage_a << (TRIT_BITS * shift_amount);

    // All trit pairs match
    assign words_equal = &equal_bits;

    // +1 in trit 0 on a match, zero elsewhere
    assign comp_word = words_equal ? word_t'(TRIT_POS) : word_t'(TRIT_ZERO);

    always_comb begin
        case (stage_opcode)
            OP_NOT: begin
                result_next = not_word;
            end
            OP_AND, OP_ANDI: begin
                result_next = and_word;
            end
            OP_OR: begin
                result_next = or_word;
            end
            OP_XOR: begin
                result_next = xor_word;
            end
            OP_ADD, OP_ADDI: begin
                result_next = sum_word;  // Wraps modulo 3^8
            end
            OP_SUB: begin
                result_next = diff_word;
            end
            OP_COMP: begin
                result_next = comp_word;
            end
            OP_SRI: begin
                result_next = shift_right;
            end
            OP_SLI: begin
                result_next = shift_left;
            end
            default: begin
                // Unknown and processor-only opcodes return A
                result_next = stage_a;
            end
        endcase
    end

    // Result holds between strobes
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= stage_valid;
            if (stage_valid) begin
                result <= result_next;
            end
        end
    end

endmodule

// ==== hdl/ternary_alu.sv ====
// Top of the two-cycle balanced-ternary ALU; operand stage, trit slices and result stage
`timescale 1ns/10ps

module ternary_alu (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  ternary_pkg::opcode_t opcode,
    input  ternary_pkg::word_t   operand_a,
    input  ternary_pkg::word_t   operand_b,
    output logic                 out_valid,
    output ternary_pkg::word_t   result
);
    import ternary_pkg::*;

    logic    stage_valid;
    opcode_t stage_opcode;
    word_t   stage_a;
    word_t   stage_b;
    shift_t  shift_amount;

    word_t   not_word;
    word_t   and_word;
    word_t   or_word;
    word_t   xor_word;
    word_t   sum_word;
    word_t   diff_word;
    logic [WORD_TRITS-1:0] equal_bits;

    // Ripple chains, entry i feeds slice i; the top carry is dropped
    trit_t   add_carry [0:WORD_TRITS];
    trit_t   sub_carry [0:WORD_TRITS];

    assign add_carry[0] = TRIT_ZERO;
    assign sub_carry[0] = TRIT_ZERO;

    operand_stage operand_stage_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .opcode       (opcode),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .stage_valid  (stage_valid),
        .stage_opcode (stage_opcode),
        .stage_a      (stage_a),
        .stage_b      (stage_b),
        .shift_amount (shift_amount)
    );

    for (genvar i = 0; i < WORD_TRITS; i++) begin : g_slice
        trit_slice trit_slice_i (
            .a_trit        (stage_a[i*TRIT_BITS +: TRIT_BITS]),
            .b_trit        (stage_b[i*TRIT_BITS +: TRIT_BITS]),
            .add_carry_in  (add_carry[i]),
            .sub_carry_in  (sub_carry[i]),
            .not_trit      (not_word[i*TRIT_BITS +: TRIT_BITS]),
            .and_trit      (and_word[i*TRIT_BITS +: TRIT_BITS]),
            .or_trit       (or_word[i*TRIT_BITS +: TRIT_BITS]),
            .xor_trit      (xor_word[i*TRIT_BITS +: TRIT_BITS]),
            .sum_trit      (sum_word[i*TRIT_BITS +: TRIT_BITS]),
            .diff_trit     (diff_word[i*TRIT_BITS +: TRIT_BITS]),
            .add_carry_out (add_carry[i+1]),
            .sub_carry_out (sub_carry[i+1]),
            .trits_equal   (equal_bits[i])
        );
    end

    result_stage result_stage_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .stage_valid  (stage_valid),
        .stage_opcode (stage_opcode),
        .stage_a      (stage_a),
        .shift_amount (shift_amount),
        .not_word     (not_word),
        .and_word     (and_word),
        .or_word      (or_word),
        .xor_word     (xor_word),
        .sum_word     (sum_word),
        .diff_word    (diff_word),
        .equal_bits   (equal_bits),
        .out_valid    (out_valid),
        .result       (result)
    );

endmodule

// ==== tests/result_checker.sv ====
// Testbench monitor for the ternary ALU; models every accepted strobe and checks each result
`timescale 1ns/10ps

module result_checker (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  ternary_pkg::opcode_t opcode,
    input  ternary_pkg::word_t   operand_a,
    input  ternary_pkg::word_t   operand_b,
    input  logic                 out_valid,
    input  ternary_pkg::word_t   result,
    input  logic                 run_done,
    output logic                 report_done,
    output int                   error_count,
    output int                   pending
);
    import ternary_pkg::*;

    localparam int MODULUS    = 3 ** WORD_TRITS;  // 6561
    localparam int HALF_RANGE = (MODULUS - 1) / 2;
    localparam int LATENCY    = 2;

    word_t   expect_q [$];
    opcode_t op_q [$];
    int      due_q [$];
    word_t   exp_word;
    opcode_t exp_op;
    int      exp_due;
    word_t   last_result = '0;
    int      cycle = 0;
    int      checked = 0;
    int      value_errors = 0;
    int      protocol_errors = 0;

    assign error_count = value_errors + protocol_errors;

    function automatic string op_name(input opcode_t op);
        case (op)
            OP_NOT:  return "NOT";
            OP_AND:  return "AND";
            OP_OR:   return "OR";
            OP_XOR:  return "XOR";
            OP_ADD:  return "ADD";
            OP_SUB:  return "SUB";
            OP_COMP: return "COMP";
            OP_ANDI: return "ANDI";
            OP_ADDI: return "ADDI";
            OP_SRI:  return "SRI";
            OP_SLI:  return "SLI";
            default: return "OTHER";
        endcase
    endfunction

    function automatic int get_trit(input word_t w, input int i);
        case (w[i*TRIT_BITS +: TRIT_BITS])
            TRIT_POS: return 1;
            TRIT_NEG: return -1;
            default:  return 0;  // 00 and 10
        endcase
    endfunction

    function automatic trit_t trit_code(input int v);
        if (v > 0) return TRIT_POS;
        if (v < 0) return TRIT_NEG;
        return TRIT_ZERO;
    endfunction

    // Weighted value with weight 1 on trit 0
    function automatic int word_value(input word_t w);
        int total;
        int weight;
        total  = 0;
        weight = 1;
        for (int i = 0; i < WORD_TRITS; i++) begin
            total  = total + get_trit(w, i) * weight;
            weight = weight * 3;
        end
        return total;
    endfunction

    // Wrap into the balanced range and peel off digits
    function automatic word_t from_value(input int v);
        int    m;
        int    r;
        word_t w;
        m = v % MODULUS;
        if (m > HALF_RANGE) m = m - MODULUS;
        else if (m < -HALF_RANGE) m = m + MODULUS;
        w = '0;
        for (int i = 0; i < WORD_TRITS; i++) begin
            r = m % 3;
            if (r > 1) r = r - 3;
            else if (r < -1) r = r + 3;
            w[i*TRIT_BITS +: TRIT_BITS] = trit_code(r);
            m = (m - r) / 3;
        end
        return w;
    endfunction

    function automatic int logic_trit(input opcode_t op, input int x, input int y);
        case (op)
            OP_NOT:          return -x;
            OP_AND, OP_ANDI: return (x < y) ? x : y;
            OP_OR:           return (x > y) ? x : y;
            default: begin
                if (x == 0) return y;
                if (y == 0) return x;
                return (x == y) ? -1 : 0;  // XOR
            end
        endcase
    endfunction

    function automatic word_t model_result(input opcode_t op, input word_t a, input word_t b);
        word_t out;
        int    count;
        int    src;
        out   = '0;
        count = 0;
        for (int i = 0; i < WORD_TRITS; i++) count = count + get_trit(b, i);
        if (count < 0) count = 0;
        if (count > WORD_TRITS - 1) count = WORD_TRITS - 1;
        case (op)
            OP_NOT, OP_AND, OP_ANDI, OP_OR, OP_XOR: begin
                for (int i = 0; i < WORD_TRITS; i++) begin
                    out[i*TRIT_BITS +: TRIT_BITS] =
                        trit_code(logic_trit(op, get_trit(a, i), get_trit(b, i)));
                end
            end
            OP_ADD, OP_ADDI: out = from_value(word_value(a) + word_value(b));
            OP_SUB:          out = from_value(word_value(a) - word_value(b));
            OP_COMP: begin
                if (word_value(a) == word_value(b)) out = word_t'(TRIT_POS);
            end
            OP_SRI, OP_SLI: begin
                for (int i = 0; i < WORD_TRITS; i++) begin
                    src = (op == OP_SRI) ? i + count : i - count;
                    if (src >= 0 && src < WORD_TRITS) begin
                        out[i*TRIT_BITS +: TRIT_BITS] = trit_code(get_trit(a, src));
                    end
                end
            end
            default: out = from_value(word_value(a));  // Normalized A
        endcase
        return out;
    endfunction

    always @(posedge clock) begin
        cycle++;
        if (!rst_n) begin
            if (out_valid) begin
                protocol_errors++;
                $display("out_valid was high during reset at cycle %0d", cycle);
            end
            expect_q.delete();
            op_q.delete();
            due_q.delete();
            report_done <= 1'b0;
        end else begin
            if (out_valid) begin
                if (due_q.size() == 0) begin
                    protocol_errors++;
                    $display("out_valid came with nothing pending at cycle %0d", cycle);
                end else begin
                    exp_word = expect_q.pop_front();
                    exp_op   = op_q.pop_front();
                    exp_due  = due_q.pop_front();
                    checked++;
                    if (exp_due != cycle) begin
                        protocol_errors++;
                        $display("Result %0d arrived at cycle %0d, expected at cycle %0d",
                                 checked, cycle, exp_due);
                    end
                    if (result !== exp_word) begin
                        value_errors++;
                        $display("Fail %s #%0d: expected %h, actual %h",
                                 op_name(exp_op), checked, exp_word, result);
                    end
                end
            end else if (result !== last_result) begin
                protocol_errors++;
                $display("result changed without out_valid at cycle %0d", cycle);
            end
            if (in_valid) begin
                expect_q.push_back(model_result(opcode, operand_a, operand_b));
                op_q.push_back(opcode);
                due_q.push_back(cycle + LATENCY);
            end
            if (run_done && !report_done) begin
                if (due_q.size() != 0) begin
                    protocol_errors = protocol_errors + due_q.size();
                    $display("%0d strobes never produced a result", due_q.size());
                end
                $display("Errors: %0d value mismatches, %0d protocol faults over %0d results",
                         value_errors, protocol_errors, checked);
                report_done <= 1'b1;
            end
        end
        last_result = result;
        pending     = due_q.size();
    end

endmodule

// ==== tests/ternary_alu_tb.sv ====
// Testbench top for the ternary ALU; seeded random traffic, reset, timeout and final verdict
`timescale 1ns/10ps

module ternary_alu_tb;
    import ternary_pkg::*;

    localparam int NUM_TRANS      = 2000;
    localparam int MAX_GAP        = 3;
    localparam int RESET_CYCLES   = 10;
    localparam int DRAIN_LIMIT    = 10;  // Last result is due two cycles after its strobe
    localparam int DRAIN_MARGIN   = 1990;
    localparam int TIMEOUT_CYCLES = NUM_TRANS * (MAX_GAP + 1) + RESET_CYCLES + DRAIN_MARGIN;

    logic    clock;
    logic    rst_n;
    logic    in_valid;
    opcode_t opcode;
    word_t   operand_a;
    word_t   operand_b;
    logic    out_valid;
    word_t   result;
    logic    run_done;
    logic    report_done;
    int      error_count;
    int      pending;
    integer  seed;
    int      cycle_count;

    ternary_alu ternary_alu_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .opcode    (opcode),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .out_valid (out_valid),
        .result    (result)
    );

    result_checker result_checker_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .opcode      (opcode),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .out_valid   (out_valid),
        .result      (result),
        .run_done    (run_done),
        .report_done (report_done),
        .error_count (error_count),
        .pending     (pending)
    );

    always #5 clock = ~clock;  // 10 ns period

    // Opcodes the ALU implements by name
    function automatic opcode_t kept_opcode(input int idx);
        case (idx)
            0:       return OP_NOT;
            1:       return OP_AND;
            2:       return OP_OR;
            3:       return OP_XOR;
            4:       return OP_ADD;
            5:       return OP_SUB;
            6:       return OP_COMP;
            7:       return OP_ANDI;
            8:       return OP_ADDI;
            9:       return OP_SRI;
            default: return OP_SLI;
        endcase
    endfunction

    // Fresh payload on every call with the strobe set as asked
    task automatic drive_random(input logic strobe);
        logic [31:0] rnd;
        rnd = $random(seed);
        if (rnd % 100 < 60) begin
            rnd    = $random(seed);
            opcode = kept_opcode(int'(rnd % 11));
        end else begin
            rnd    = $random(seed);
            opcode = rnd[5:0];  // Any 6-bit pattern
        end
        rnd       = $random(seed);
        operand_a = rnd[15:0];
        operand_b = rnd[31:16];
        if (strobe && opcode == OP_COMP) begin
            rnd = $random(seed);
            if (rnd % 10 == 0) begin
                operand_b = operand_a;  // Force a match now and then
            end
        end
        in_valid = strobe;
    endtask

    initial begin
        logic [31:0] rnd;
        int          gap;
        int          drain;
        clock     = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        opcode    = '0;
        operand_a = '0;
        operand_b = '0;
        run_done  = 1'b0;
        seed      = 23;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        repeat (3) @(negedge clock);  // Quiet cycles before the first strobe
        for (int n = 0; n < NUM_TRANS; n++) begin
            @(negedge clock);
            drive_random(1'b1);
            rnd = $random(seed);
            gap = int'(rnd[1:0]);
            repeat (gap) begin
                @(negedge clock);
                drive_random(1'b0);
            end
        end
        @(negedge clock);
        in_valid = 1'b0;
        drain    = 0;
        // Bounded wait for the last results
        while (pending != 0 && drain < DRAIN_LIMIT) begin
            @(negedge clock);
            drain++;
        end
        repeat (3) @(negedge clock);
        run_done = 1'b1;
        wait (report_done == 1'b1);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Hard stop if the run never completes
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== ternary_alu.f ====
hdl/ternary_pkg.sv
hdl/operand_stage.sv
hdl/trit_slice.sv
hdl/result_stage.sv
hdl/ternary_alu.sv
tests/result_checker.sv
tests/ternary_alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the ternary ALU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" &&
verilator --binary --timing -f ternary_alu.f --top-module ternary_alu_tb \
    -Mdir obj_dir -o ternary_alu_sim > build.log 2>&1 &&
./obj_dir/ternary_alu_sim > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "Simulation finished: PASS" sim.log 2>/dev/null &&
echo "Run passed" ||
{ echo "Run failed, see build.log and sim.log"; exit 1; }

exit 0
